// File: all.f
+incdir+design
design/sb_pkg.sv
design/sb_interconnect_m2_s1.sv
design/sb_register_bank.sv
design/pwm_generator.sv
design/sb_pwm_subsystem.sv
test/tb_sb_pwm_subsystem.sv

// File: Makefile
# Verilator simulation of the PWM subsystem

VERILATOR ?= verilator
TOP ?= tb_sb_pwm_subsystem
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing
PASS_TEXT ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VERILATOR_FLAGS"

# The run passes only when the pass message shows up in the output
test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_sb_pwm_subsystem.sv
// PWM subsystem testbench
`timescale 1ns/100ps
`include "sb_defines.svh"

module tb_sb_pwm_subsystem;

    import sb_pkg::*;

    // Longest wait for a ready pulse, also the quiet time for rejected accesses
    localparam int ACCESS_TIMEOUT = 8;

    // Two interconnect stages plus the register bank
    localparam int READY_LATENCY = 3;

    // Period and duty keep only the counter width
    localparam sb_data_t COUNT_MASK = {{(`SB_DATA_WIDTH-`PWM_COUNT_WIDTH){1'b0}},
                                       {`PWM_COUNT_WIDTH{1'b1}}};
    localparam sb_data_t ENABLE_MASK = sb_data_t'(1) << `CTRL_ENABLE_BIT;

    logic         clock;
    logic         rst_n;
    sb_request_t  master_1_request;
    sb_request_t  master_2_request;
    sb_response_t master_1_response;
    sb_response_t master_2_response;
    logic         pwm_out;
    logic         cycle_start;

    // Expected contents of ctrl, period, duty and scratch
    sb_data_t reg_model [4];

    sb_pwm_subsystem u_sb_pwm_subsystem (
        .clock             (clock),
        .rst_n             (rst_n),
        .master_1_request  (master_1_request),
        .master_2_request  (master_2_request),
        .master_1_response (master_1_response),
        .master_2_response (master_2_response),
        .pwm_out           (pwm_out),
        .cycle_start       (cycle_start)
    );

    always #5 clock = ~clock;

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input sb_data_t actual,
                               input sb_data_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic report_error(input string reason);
        $display("Error: %s", reason);
        stop_on_error();
    endtask

    function automatic logic [1:0] index_of(input sb_addr_t address);
        return address[`REG_INDEX_MSB:`REG_INDEX_LSB];
    endfunction

    function automatic sb_addr_t register_address(input logic [1:0] index);
        return `SB_SLAVE_LOW + sb_addr_t'({index, 2'b00});
    endfunction

    // Any byte address in the window, aligned or not
    function automatic sb_addr_t random_window_address();
        return `SB_SLAVE_LOW + sb_addr_t'($urandom_range(`SB_SLAVE_HIGH - `SB_SLAVE_LOW - 1, 0));
    endfunction

    // Both window edges are tried as well as fully random addresses
    function automatic sb_addr_t random_outside_address();
        sb_addr_t address;
        case ($urandom_range(2, 0))
            0: address = `SB_SLAVE_HIGH;
            1: address = `SB_SLAVE_LOW - 1;
            default: begin
                address = sb_addr_t'($urandom());
                if (address >= `SB_SLAVE_LOW && address < `SB_SLAVE_HIGH) begin
                    address = address ^ 32'h8000_0000;
                end
            end
        endcase
        return address;
    endfunction

    function automatic int random_master();
        return int'($urandom_range(2, 1));
    endfunction

    function automatic sb_request_t make_request(input sb_addr_t address, input logic is_write,
                                                 input sb_data_t data);
        sb_request_t request;
        request = '0;
        request.address = address;
        request.write_strobe = is_write;
        request.read_strobe = !is_write;
        if (is_write) begin
            request.write_data = data;
        end
        return request;
    endfunction

    // A write updates the model the way the register bank stores it
    task automatic model_write(input sb_addr_t address, input sb_data_t data);
        logic [1:0] index;
        index = index_of(address);
        if (index == `REG_PERIOD || index == `REG_DUTY) begin
            reg_model[index] = data & COUNT_MASK;
        end else begin
            reg_model[index] = data;
        end
    endtask

    // The time the strobe is driven counts as cycle zero
    task automatic run_access(input sb_request_t request_1, input sb_request_t request_2,
                              input logic expect_ready, output sb_data_t read_data_1,
                              output sb_data_t read_data_2);
        int   cycles;
        logic got_ready;
        cycles = 0;
        got_ready = 1'b0;
        read_data_1 = '0;
        read_data_2 = '0;
        @(negedge clock);
        master_1_request = request_1;
        master_2_request = request_2;
        // A ready on either master ends the wait
        while (!got_ready && cycles < ACCESS_TIMEOUT) begin
            @(negedge clock);
            master_1_request = '0;
            master_2_request = '0;
            cycles++;
            got_ready = master_1_response.ready | master_2_response.ready;
        end
        if (expect_ready) begin
            if (!got_ready) begin
                report_error("no ready pulse arrived within the access timeout");
            end
            check_value("ready latency", sb_data_t'(cycles), sb_data_t'(READY_LATENCY));
            // The response is broadcast, so both masters get the pulse
            check_value("master_1_response.ready", sb_data_t'(master_1_response.ready), 32'h1);
            check_value("master_2_response.ready", sb_data_t'(master_2_response.ready), 32'h1);
            read_data_1 = master_1_response.read_data;
            read_data_2 = master_2_response.read_data;
            // A second ready would mean a dropped request got through
            @(negedge clock);
            check_value("master_1_response.ready", sb_data_t'(master_1_response.ready), 32'h0);
            check_value("master_2_response.ready", sb_data_t'(master_2_response.ready), 32'h0);
        end else if (got_ready) begin
            report_error("an access outside the slave window produced a ready pulse");
        end
    endtask

    task automatic write_register(input int master, input sb_addr_t address, input sb_data_t data);
        sb_request_t request;
        sb_data_t    ignored_data;
        request = make_request(address, 1'b1, data);
        if (master == 1) begin
            run_access(request, '0, 1'b1, ignored_data, ignored_data);
        end else begin
            run_access('0, request, 1'b1, ignored_data, ignored_data);
        end
        model_write(address, data);
    endtask

    task automatic read_register_check(input int master, input sb_addr_t address);
        sb_request_t request;
        sb_data_t    read_data_1;
        sb_data_t    read_data_2;
        request = make_request(address, 1'b0, '0);
        if (master == 1) begin
            run_access(request, '0, 1'b1, read_data_1, read_data_2);
        end else begin
            run_access('0, request, 1'b1, read_data_1, read_data_2);
        end
        check_value("master_1_response.read_data", read_data_1, reg_model[index_of(address)]);
        check_value("master_2_response.read_data", read_data_2, reg_model[index_of(address)]);
    endtask

    task automatic read_all_registers();
        for (int i = 0; i < 4; i++) begin
            read_register_check(random_master(), register_address(2'(i)));
        end
    endtask

    task automatic expect_outputs_low(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_value("pwm_out", sb_data_t'(pwm_out), 32'h0);
            check_value("cycle_start", sb_data_t'(cycle_start), 32'h0);
        end
    endtask

    task automatic wait_cycle_start(input int limit);
        int   cycles;
        logic found;
        cycles = 0;
        found = 1'b0;
        while (!found && cycles < limit) begin
            @(negedge clock);
            cycles++;
            found = cycle_start;
        end
        if (!found) begin
            report_error("cycle_start did not pulse while the generator was enabled");
        end
    endtask

    // Starts in a cycle where cycle_start is high and ends at the next one
    task automatic measure_period(input int expected_period, input int expected_high);
        int   length;
        int   high_count;
        logic next_start;
        length = 1;
        high_count = pwm_out ? 1 : 0;
        next_start = 1'b0;
        while (!next_start && length <= expected_period + 2) begin
            @(negedge clock);
            next_start = cycle_start;
            if (!next_start) begin
                length++;
                if (pwm_out) begin
                    high_count++;
                end
            end
        end
        if (!next_start) begin
            report_error("cycle_start did not return at the end of a period");
        end
        check_value("period length", sb_data_t'(length), sb_data_t'(expected_period));
        check_value("pwm_out high cycles", sb_data_t'(high_count), sb_data_t'(expected_high));
    endtask

    // Duty at or above the period keeps the output high all period
    function automatic int expected_high(input int period, input int duty);
        return (duty < period) ? duty : period;
    endfunction

    // Stop first so the shadows pick up the new values before restarting
    task automatic configure_pwm(input int period, input int duty);
        write_register(random_master(), register_address(`REG_CTRL),
                       sb_data_t'($urandom()) & ~ENABLE_MASK);
        // Junk in the upper half checks the masking on the way
        write_register(random_master(), register_address(`REG_PERIOD),
                       (sb_data_t'($urandom()) << 16) | sb_data_t'(period));
        write_register(random_master(), register_address(`REG_DUTY),
                       (sb_data_t'($urandom()) << 16) | sb_data_t'(duty));
        write_register(random_master(), register_address(`REG_CTRL),
                       sb_data_t'($urandom()) | ENABLE_MASK);
    endtask

    initial begin
        sb_request_t request_1;
        sb_request_t request_2;
        sb_data_t    data_1;
        sb_data_t    ignored_data;
        int          period;
        int          duty;
        int          new_duty;
        clock = 1'b0;
        rst_n = 1'b0;
        master_1_request = '0;
        master_2_request = '0;
        void'($urandom(21));
        for (int i = 0; i < 4; i++) begin
            reg_model[i] = '0;
        end
        // Reset is held over three rising edges
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // Quiet outputs and cleared registers out of reset
        expect_outputs_low(20);
        read_all_registers();

        // Random traffic from either master inside the window
        repeat (60) begin
            if ($urandom_range(1, 0) == 1) begin
                write_register(random_master(), random_window_address(), sb_data_t'($urandom()));
            end else begin
                read_register_check(random_master(), random_window_address());
            end
        end

        // Master 1 wins a tie and the master 2 write is lost
        repeat (8) begin
            data_1 = sb_data_t'($urandom());
            request_1 = make_request(register_address(`REG_SCRATCH), 1'b1, data_1);
            request_2 = make_request(register_address(2'($urandom_range(3, 0))), 1'b1, ~data_1);
            run_access(request_1, request_2, 1'b1, ignored_data, ignored_data);
            model_write(request_1.address, data_1);
            read_all_registers();
        end

        // Rejected accesses get no ready and change nothing
        repeat (12) begin
            request_1 = make_request(random_outside_address(), $urandom_range(1, 0) == 1,
                                     sb_data_t'($urandom()));
            if (random_master() == 1) begin
                run_access(request_1, '0, 1'b0, ignored_data, ignored_data);
            end else begin
                run_access('0, request_1, 1'b0, ignored_data, ignored_data);
            end
        end
        read_all_registers();

        // Random settings, including a duty above the period
        repeat (5) begin
            period = int'($urandom_range(24, 1));
            duty = int'($urandom_range(period + 4, 0));
            configure_pwm(period, duty);
            wait_cycle_start(2 * period + 8);
            measure_period(period, expected_high(period, duty));
            measure_period(period, expected_high(period, duty));
        end

        // A duty written mid-period waits for the next cycle_start
        period = int'($urandom_range(60, 30));
        duty = int'($urandom_range(period / 2 - 1, 2));
        new_duty = int'($urandom_range(period + 4, period / 2 + 1));
        configure_pwm(period, duty);
        wait_cycle_start(2 * period + 8);
        fork
            measure_period(period, duty);
            write_register(random_master(), register_address(`REG_DUTY), sb_data_t'(new_duty));
        join
        measure_period(period, expected_high(period, new_duty));
        measure_period(period, expected_high(period, new_duty));

        // Clearing enable silences both outputs
        write_register(random_master(), register_address(`REG_CTRL),
                       sb_data_t'($urandom()) & ~ENABLE_MASK);
        expect_outputs_low(2 * period);
        read_all_registers();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: design/sb_pwm_subsystem.sv
// Bus attached PWM subsystem
`timescale 1ns/100ps
`include "sb_defines.svh"

module sb_pwm_subsystem (
    input  logic                 clock,
    input  logic                 rst_n,
    input  sb_pkg::sb_request_t  master_1_request,
    input  sb_pkg::sb_request_t  master_2_request,
    output sb_pkg::sb_response_t master_1_response,
    output sb_pkg::sb_response_t master_2_response,
    output logic                 pwm_out,
    output logic                 cycle_start
);

    import sb_pkg::*;

    // Request leaving the interconnect toward the register bank
    sb_request_t  slave_request;

    // Response from the register bank, broadcast to both masters
    sb_response_t slave_response;

    // Live settings from the register bank
    pwm_config_t  pwm_config;

    // Two pipeline stages of master selection and window check
    sb_interconnect_m2_s1 #(
        .slave_low  (`SB_SLAVE_LOW),
        .slave_high (`SB_SLAVE_HIGH)
    ) u_interconnect (
        .clock             (clock),
        .rst_n             (rst_n),
        .master_1_request  (master_1_request),
        .master_2_request  (master_2_request),
        .master_1_response (master_1_response),
        .master_2_response (master_2_response),
        .slave_request     (slave_request),
        .slave_response    (slave_response)
    );

    // One more cycle to ready, giving three cycles from strobe to response
    sb_register_bank u_register_bank (
        .clock      (clock),
        .rst_n      (rst_n),
        .request    (slave_request),
        .response   (slave_response),
        .pwm_config (pwm_config)
    );

    // New settings are picked up at period boundaries only
    pwm_generator u_pwm_generator (
        .clock       (clock),
        .rst_n       (rst_n),
        .pwm_config  (pwm_config),
        .pwm_out     (pwm_out),
        .cycle_start (cycle_start)
    );

endmodule

// File: design/pwm_generator.sv
// Single channel PWM generator
`timescale 1ns/100ps

module pwm_generator (
    input  logic                clock,
    input  logic                rst_n,
    input  sb_pkg::pwm_config_t pwm_config,
    output logic                pwm_out,
    output logic                cycle_start
);

    import sb_pkg::*;

    // Counter runs from zero to the shadow period minus one
    pwm_count_t counter;

    // Settings in use for the current period
    pwm_count_t shadow_period;
    pwm_count_t shadow_duty;

    // Counting needs the enable bit and a nonzero period
    logic       running;

    // Last count of the current period
    logic       wrap;

    assign running = pwm_config.enable && (shadow_period != '0);
    assign wrap = (counter == pwm_count_t'(shadow_period - 1'b1));

    // Shadows follow the live settings while stopped and are sampled again at each wrap
    // A period that becomes zero at a wrap stops the generator from the next cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            counter <= '0;
            shadow_period <= '0;
            shadow_duty <= '0;
        end else if (!running || wrap) begin
            counter <= '0;
            shadow_period <= pwm_config.period;
            shadow_duty <= pwm_config.duty;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // Outputs are registered, so they trail the counter by one cycle
    // A duty at or above the period keeps the output high for the whole period
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pwm_out <= 1'b0;
            cycle_start <= 1'b0;
        end else begin
            pwm_out <= running && (counter < shadow_duty);
            cycle_start <= running && (counter == '0);
        end
    end

endmodule

// File: design/sb_register_bank.sv
// PWM register bank slave
`timescale 1ns/100ps
`include "sb_defines.svh"

module sb_register_bank (
    input  logic                 clock,
    input  logic                 rst_n,
    input  sb_pkg::sb_request_t  request,
    output sb_pkg::sb_response_t response,
    output sb_pkg::pwm_config_t  pwm_config
);

    import sb_pkg::*;

    // Word index of the addressed register
    logic [1:0] reg_index;

    // Control word, bit 0 enables the generator and the rest is free storage
    sb_data_t   ctrl_reg;

    // Only the counter width is stored for period and duty
    pwm_count_t period_reg;
    pwm_count_t duty_reg;

    // General purpose word with no effect on the hardware
    sb_data_t   scratch_reg;

    // Read value of the addressed register before it is registered
    sb_data_t   read_value;

    // High for either kind of access
    logic       access;

    // The interconnect already checked the window, so only the index bits matter
    assign reg_index = request.address[`REG_INDEX_MSB:`REG_INDEX_LSB];
    assign access = request.read_strobe | request.write_strobe;

    // Register writes take effect at the edge that samples the strobe
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl_reg <= '0;
            period_reg <= '0;
            duty_reg <= '0;
            scratch_reg <= '0;
        end else if (request.write_strobe) begin
            case (reg_index)
                `REG_CTRL: begin
                    ctrl_reg <= request.write_data;
                end
                `REG_PERIOD: begin
                    // Upper bits of the word are dropped here
                    period_reg <= pwm_count_t'(request.write_data);
                end
                `REG_DUTY: begin
                    duty_reg <= pwm_count_t'(request.write_data);
                end
                `REG_SCRATCH: begin
                    scratch_reg <= request.write_data;
                end
            endcase
        end
    end

    // Period and duty are zero extended, so their upper bits read as zero
    always_comb begin
        case (reg_index)
            `REG_CTRL: read_value = ctrl_reg;
            `REG_PERIOD: read_value = sb_data_t'(period_reg);
            `REG_DUTY: read_value = sb_data_t'(duty_reg);
            `REG_SCRATCH: read_value = scratch_reg;
        endcase
    end

    // Ready pulses one cycle after any strobe
    // Read data is only driven for reads and is zero otherwise
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            response <= '0;
        end else begin
            response.ready <= access;
            if (request.read_strobe) begin
                response.read_data <= read_value;
            end else begin
                response.read_data <= '0;
            end
        end
    end

    // Live settings go straight to the generator
    // The generator's shadow registers decide when they are used
    assign pwm_config.enable = ctrl_reg[`CTRL_ENABLE_BIT];
    assign pwm_config.period = period_reg;
    assign pwm_config.duty = duty_reg;

endmodule

// File: design/sb_interconnect_m2_s1.sv
// Two-master simple bus interconnect
`timescale 1ns/100ps
`include "sb_defines.svh"

module sb_interconnect_m2_s1 #(
    parameter sb_pkg::sb_addr_t slave_low = `SB_SLAVE_LOW,
    parameter sb_pkg::sb_addr_t slave_high = `SB_SLAVE_HIGH
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  sb_pkg::sb_request_t  master_1_request,
    input  sb_pkg::sb_request_t  master_2_request,
    output sb_pkg::sb_response_t master_1_response,
    output sb_pkg::sb_response_t master_2_response,
    output sb_pkg::sb_request_t  slave_request,
    input  sb_pkg::sb_response_t slave_response
);

    import sb_pkg::*;

    // A master is active in any cycle where it raises one of its strobes
    logic        master_1_active;
    logic        master_2_active;

    // Request chosen by the priority logic, before it is registered
    sb_request_t selected_next;

    // First pipeline stage holding the winning request
    sb_request_t selected_request;

    // High when the held request targets the slave window
    logic        in_window;

    assign master_1_active = master_1_request.read_strobe | master_1_request.write_strobe;
    assign master_2_active = master_2_request.read_strobe | master_2_request.write_strobe;

    // Master 1 has fixed priority
    // A master 2 request in the same cycle is lost and never retried
    always_comb begin
        if (master_1_active) begin
            selected_next = master_1_request;
        end else if (master_2_active) begin
            selected_next = master_2_request;
        end else begin
            selected_next = '0;
        end
    end

    // An idle cycle loads zeros so that no stale strobe survives
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            selected_request <= '0;
        end else begin
            selected_request <= selected_next;
        end
    end

    // Base is inclusive and end is exclusive
    assign in_window = (selected_request.address >= slave_low) &&
                       (selected_request.address < slave_high);

    // Second stage passes the request on only inside the window
    // Outside the window the slave sees an idle request with every field zero
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            slave_request <= '0;
        end else if (in_window) begin
            slave_request <= selected_request;
        end else begin
            slave_request <= '0;
        end
    end

    // Both masters see the same response
    // A master that did not win simply ignores the ready pulse
    assign master_1_response = slave_response;
    assign master_2_response = slave_response;

endmodule

// File: design/sb_pkg.sv
// Simple bus and PWM types
`include "sb_defines.svh"

package sb_pkg;

    // Byte address on the simple bus
    typedef logic [`SB_ADDR_WIDTH-1:0] sb_addr_t;

    // One bus data word
    typedef logic [`SB_DATA_WIDTH-1:0] sb_data_t;

    // Value of the PWM counter, also used for period and duty
    typedef logic [`PWM_COUNT_WIDTH-1:0] pwm_count_t;

    // Request from a master
    // Strobes are single-cycle pulses and never high together
    typedef struct packed {
        sb_addr_t address;
        logic     read_strobe;
        logic     write_strobe;
        sb_data_t write_data;
    } sb_request_t;

    // Response from the slave
    // Read data is valid in the same cycle as the ready pulse
    typedef struct packed {
        sb_data_t read_data;
        logic     ready;
    } sb_response_t;

    // Settings handed from the register bank to the generator
    typedef struct packed {
        logic       enable;
        pwm_count_t period;
        pwm_count_t duty;
    } pwm_config_t;

endpackage

// File: design/sb_defines.svh
// Simple bus PWM constants
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// Bus address width in bits
`define SB_ADDR_WIDTH 32

// Bus data width in bits
`define SB_DATA_WIDTH 32

// Width of the PWM period counter and of the period and duty settings
`define PWM_COUNT_WIDTH 16

// Default slave window, the base is included and the end is excluded
`define SB_SLAVE_LOW 32'h4000_0000
`define SB_SLAVE_HIGH 32'h4000_0010

// The register index comes from these address bits, so registers sit on word boundaries
`define REG_INDEX_MSB 3
`define REG_INDEX_LSB 2

// Word indices of the four registers in the bank
`define REG_CTRL 2'd0
`define REG_PERIOD 2'd1
`define REG_DUTY 2'd2
`define REG_SCRATCH 2'd3

// Bit of the control register that enables the generator
`define CTRL_ENABLE_BIT 0

`endif
